/* rtl/outrun_cfg_pkg.sv */
// Game configuration struct, header byte offsets and status selector
package outrun_cfg_pkg;

    // Header byte offsets within the download header
    parameter logic [3:0] HDR_DEC_BYTE = 4'd0;
    parameter logic [3:0] HDR_ID_BYTE  = 4'd1;

    // Decryption options and game variant from the ROM header
    typedef struct packed {
        logic       dec_en;
        logic       dec_type;
        logic [1:0] game_id;
    } game_cfg_t;

    // Status dump selector, taken from st_addr bits 1:0
    typedef enum logic [1:0] {
        ST_CFG       = 2'd0,
        ST_MAIN_CRED = 2'd1,
        ST_SUB_CRED  = 2'd2,
        ST_KEY       = 2'd3
    } st_sel_e;

endpackage

/* rtl/outrun_bus_pkg.sv */
// Main and sub CPU request structs, SDRAM request and response structs, bank selector
package outrun_bus_pkg;

    // Main CPU request, addr holds word address bits 19:1
    typedef struct packed {
        logic [18:0] addr;
        logic [1:0]  dsn;
        logic        rnw;
        logic [15:0] din;
    } cpu_req_t;

    // Sub CPU request
    typedef struct packed {
        logic [13:0] addr;
        logic [1:0]  dsn;
        logic        rnw;
        logic [15:0] din;
    } sub_req_t;

    // SDRAM bank of the main slot
    typedef enum logic {
        BANK_ROM  = 1'b0,
        BANK_XRAM = 1'b1
    } mem_bank_e;

    // Main SDRAM slot request
    typedef struct packed {
        mem_bank_e   bank;
        logic [17:0] addr;
        logic [1:0]  dsn;
        logic        we;
        logic [15:0] din;
    } mem_req_t;

    // Response word, shared by both slots and the CPU return
    typedef struct packed {
        logic [15:0] data;
    } mem_rsp_t;

endpackage

/* rtl/game_cfg_regs.sv */
// Header configuration registers, key table write decode and status dump
`timescale 1ns/10ps

module game_cfg_regs #(
    parameter logic [21:0] KEY_BASE = 22'h10_0000
) (
    input  logic                      clk,
    input  logic                      reset,
    // Download stream
    input  logic [21:0]               prog_addr,
    input  logic [7:0]                prog_data,
    input  logic                      prog_we,
    input  logic                      prom_we,
    input  logic                      header,
    // Status sources
    input  logic [7:0]                st_addr,
    input  logic [2:0]                main_credits,
    input  logic [2:0]                sub_credits,
    input  logic [7:0]                key_data,
    // Outputs
    output outrun_cfg_pkg::game_cfg_t cfg,
    output logic                      key_we,
    output logic [12:0]               key_wr_addr,
    output logic [7:0]                st_dout
);

    logic hdr_wr;
    logic key_hit;

    assign hdr_wr = header && prog_we;

    // Key table occupies one 8 KB window of the download space
    assign key_hit     = prog_addr[21:13] == KEY_BASE[21:13];
    assign key_we      = prom_we && key_hit;
    assign key_wr_addr = prog_addr[12:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '0;
        end else if (hdr_wr) begin
            if (prog_addr[3:0] == outrun_cfg_pkg::HDR_DEC_BYTE) begin
                cfg.dec_type <= prog_data[0];
                cfg.dec_en   <= prog_data[1];
            end
            if (prog_addr[3:0] == outrun_cfg_pkg::HDR_ID_BYTE) begin
                cfg.game_id <= prog_data[1:0];
            end
        end
    end

    // Status readback, one cycle after st_addr
    always_ff @(posedge clk) begin
        case (outrun_cfg_pkg::st_sel_e'(st_addr[1:0]))
            outrun_cfg_pkg::ST_CFG: begin
                st_dout <= {4'b0000, cfg.game_id, cfg.dec_type, cfg.dec_en};
            end
            outrun_cfg_pkg::ST_MAIN_CRED: begin
                st_dout <= {5'b00000, main_credits};
            end
            outrun_cfg_pkg::ST_SUB_CRED: begin
                st_dout <= {5'b00000, sub_credits};
            end
            default: begin
                // Last byte read from the key table
                st_dout <= key_data;
            end
        endcase
    end

endmodule

/* rtl/key_prom.sv */
// Protection key table, 8K by 8, download write port and registered read port
`timescale 1ns/10ps

module key_prom (
    input  logic        clk,
    // Download side
    input  logic        we,
    input  logic [12:0] wr_addr,
    input  logic [7:0]  wr_data,
    // Decryption side
    input  logic [12:0] rd_addr,
    output logic [7:0]  q
);

    logic [7:0] mem [0:8191];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Key byte is ready the cycle after the address
    always_ff @(posedge clk) begin
        q <= mem[rd_addr];
    end

endmodule

/* rtl/main_mem_map.sv */
// Main bus region decode, SDRAM request forming, response tag queue and ROM decryption
`timescale 1ns/10ps

module main_mem_map #(
    parameter int DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  outrun_cfg_pkg::game_cfg_t cfg,
    // CPU side
    input  logic                      cpu_valid,
    input  outrun_bus_pkg::cpu_req_t  cpu_req,
    output logic                      cpu_ready,
    output logic                      cpu_rsp_valid,
    output outrun_bus_pkg::mem_rsp_t  cpu_rsp,
    // Key table
    output logic [12:0]               key_addr,
    input  logic [7:0]                key_data,
    // SDRAM slot
    output logic                      tx_valid,
    output outrun_bus_pkg::mem_req_t  tx_req,
    input  logic                      tx_ready,
    input  logic                      mem_rsp_valid,
    input  outrun_bus_pkg::mem_rsp_t  mem_rsp
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);
    localparam logic [CW-1:0] FULL = CW'(DEPTH);

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] fill_ptr;
    logic [CW-1:0] count;
    logic          fill_pend;
    logic          room;
    logic          push;
    logic          pop;
    logic          is_rom;
    logic [7:0]    key_sel;
    logic [15:0]   rsp_data;

    // Tag entries, one per request in flight
    logic          tag_rom  [0:DEPTH-1];
    logic          tag_type [0:DEPTH-1];
    logic          tag_en   [0:DEPTH-1];
    logic [7:0]    tag_key  [0:DEPTH-1];

    assign room      = count != FULL;
    assign cpu_ready = tx_ready && room;
    assign tx_valid  = cpu_valid && room;
    assign push      = cpu_valid && cpu_ready;
    assign pop       = mem_rsp_valid;
    assign key_addr  = cpu_req.addr[12:0];

    // Bits 19:18 select ROM, work RAM or VRAM
    assign is_rom = ~cpu_req.addr[18];

    always_comb begin
        tx_req.dsn = cpu_req.dsn;
        tx_req.din = cpu_req.din;
        if (is_rom) begin
            tx_req.bank = outrun_bus_pkg::BANK_ROM;
            tx_req.addr = cpu_req.addr[17:0];
            tx_req.we   = 1'b0;
        end else begin
            // Work RAM sits above VRAM in XRAM
            tx_req.bank = outrun_bus_pkg::BANK_XRAM;
            tx_req.addr = {3'b000, ~cpu_req.addr[17], cpu_req.addr[13:0]};
            tx_req.we   = ~cpu_req.rnw;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            fill_pend <= 1'b0;
        end else begin
            fill_pend <= push;
            if (push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            tag_rom[wr_ptr]  <= is_rom && cpu_req.rnw;
            tag_type[wr_ptr] <= cfg.dec_type;
            tag_en[wr_ptr]   <= cfg.dec_en;
            fill_ptr         <= wr_ptr;
        end
        // Key byte arrives one cycle after acceptance
        if (fill_pend) begin
            tag_key[fill_ptr] <= key_data;
        end
    end

    always_comb begin
        key_sel  = (fill_pend && fill_ptr == rd_ptr) ? key_data : tag_key[rd_ptr];
        rsp_data = mem_rsp.data;
        if (tag_rom[rd_ptr] && tag_en[rd_ptr]) begin
            if (tag_type[rd_ptr]) begin
                rsp_data = mem_rsp.data ^ {key_sel, ~key_sel};
            end else begin
                rsp_data = mem_rsp.data ^ {key_sel, key_sel};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cpu_rsp_valid <= 1'b0;
        end else begin
            cpu_rsp_valid <= mem_rsp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rsp_valid) begin
            cpu_rsp.data <= rsp_data;
        end
    end

    // A new tag never lands on an entry still waiting for its response
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> (count == '0) || (wr_ptr != rd_ptr))
        else $error("tag queue overflow");

    // Memory must never answer more requests than were sent
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> count != '0)
        else $error("response with empty tag queue");

endmodule

/* rtl/credit_tx.sv */
// Credit-based request sender with a registered payload, generic over the payload type
`timescale 1ns/10ps

module credit_tx #(
    parameter type payload_t = logic [15:0],
    parameter int  CREDITS   = 2
) (
    input  logic       clk,
    input  logic       reset,
    // Request side
    input  logic       in_valid,
    input  payload_t   in_payload,
    output logic       in_ready,
    // Slot side
    output logic       out_valid,
    output payload_t   out_payload,
    input  logic       credit_return,
    // Free credits for status
    output logic [2:0] credits
);

    localparam logic [2:0] FULL = 3'(CREDITS);

    logic [2:0] cnt;
    logic       take;

    assign in_ready = cnt != 3'd0;
    assign take     = in_valid && in_ready;
    assign credits  = cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt       <= FULL;
            out_valid <= 1'b0;
        end else begin
            out_valid <= take;
            case ({take, credit_return})
                2'b10:   cnt <= cnt - 1'b1;
                2'b01:   cnt <= cnt + 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    // Payload held one cycle with out_valid
    always_ff @(posedge clk) begin
        if (take) begin
            out_payload <= in_payload;
        end
    end

    a_cnt_bound: assert property (@(posedge clk) disable iff (reset)
        cnt <= FULL)
        else $error("credit count above limit");

    // Slot returns only credits it was given
    a_no_extra_return: assert property (@(posedge clk) disable iff (reset)
        credit_return |-> cnt != FULL)
        else $error("credit returned while all credits are free");

endmodule

/* rtl/outrun_game.sv */
// Game top level with configuration, key table, main bus map and two SDRAM credit slots
`timescale 1ns/10ps

module outrun_game #(
    parameter logic [21:0] KEY_BASE     = 22'h10_0000,
    parameter int          MAIN_CREDITS = 4,
    parameter int          SUB_CREDITS  = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    // Download
    input  logic [21:0]              prog_addr,
    input  logic [7:0]               prog_data,
    input  logic                     prog_we,
    input  logic                     prom_we,
    input  logic                     header,
    output logic [1:0]               game_id,
    // Status dump
    input  logic [7:0]               st_addr,
    output logic [7:0]               st_dout,
    // Main CPU bus
    input  logic                     cpu_valid,
    input  outrun_bus_pkg::cpu_req_t cpu_req,
    output logic                     cpu_ready,
    output logic                     cpu_rsp_valid,
    output outrun_bus_pkg::mem_rsp_t cpu_rsp,
    // Sub CPU bus
    input  logic                     sub_valid,
    input  outrun_bus_pkg::sub_req_t sub_req,
    output logic                     sub_ready,
    output logic                     sub_rsp_valid,
    output outrun_bus_pkg::mem_rsp_t sub_rsp,
    // Main SDRAM slot
    output logic                     main_mem_valid,
    output outrun_bus_pkg::mem_req_t main_mem_req,
    input  logic                     main_credit_return,
    input  logic                     main_rsp_valid,
    input  outrun_bus_pkg::mem_rsp_t main_rsp,
    // Sub SDRAM slot
    output logic                     sub_mem_valid,
    output outrun_bus_pkg::sub_req_t sub_mem_req,
    input  logic                     sub_credit_return,
    input  logic                     sub_mem_rsp_valid,
    input  outrun_bus_pkg::mem_rsp_t sub_mem_rsp
);

    outrun_cfg_pkg::game_cfg_t cfg;
    outrun_bus_pkg::mem_req_t  tx_req;
    logic                      tx_valid;
    logic                      tx_ready;
    logic                      key_we;
    logic [12:0]               key_wr_addr;
    logic [12:0]               key_addr;
    logic [7:0]                key_data;
    logic [2:0]                main_credits;
    logic [2:0]                sub_credits;

    assign game_id       = cfg.game_id;
    // Sub responses need no tagging
    assign sub_rsp_valid = sub_mem_rsp_valid;
    assign sub_rsp       = sub_mem_rsp;

    game_cfg_regs #(.KEY_BASE(KEY_BASE)) u_cfg (
        .clk         (clk),
        .reset       (reset),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_we     (prog_we),
        .prom_we     (prom_we),
        .header      (header),
        .st_addr     (st_addr),
        .main_credits(main_credits),
        .sub_credits (sub_credits),
        .key_data    (key_data),
        .cfg         (cfg),
        .key_we      (key_we),
        .key_wr_addr (key_wr_addr),
        .st_dout     (st_dout)
    );

    key_prom u_key (
        .clk    (clk),
        .we     (key_we),
        .wr_addr(key_wr_addr),
        .wr_data(prog_data),
        .rd_addr(key_addr),
        .q      (key_data)
    );

    main_mem_map #(.DEPTH(MAIN_CREDITS)) u_map (
        .clk          (clk),
        .reset        (reset),
        .cfg          (cfg),
        .cpu_valid    (cpu_valid),
        .cpu_req      (cpu_req),
        .cpu_ready    (cpu_ready),
        .cpu_rsp_valid(cpu_rsp_valid),
        .cpu_rsp      (cpu_rsp),
        .key_addr     (key_addr),
        .key_data     (key_data),
        .tx_valid     (tx_valid),
        .tx_req       (tx_req),
        .tx_ready     (tx_ready),
        .mem_rsp_valid(main_rsp_valid),
        .mem_rsp      (main_rsp)
    );

    credit_tx #(
        .payload_t(outrun_bus_pkg::mem_req_t),
        .CREDITS  (MAIN_CREDITS)
    ) u_main_tx (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (tx_valid),
        .in_payload   (tx_req),
        .in_ready     (tx_ready),
        .out_valid    (main_mem_valid),
        .out_payload  (main_mem_req),
        .credit_return(main_credit_return),
        .credits      (main_credits)
    );

    credit_tx #(
        .payload_t(outrun_bus_pkg::sub_req_t),
        .CREDITS  (SUB_CREDITS)
    ) u_sub_tx (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (sub_valid),
        .in_payload   (sub_req),
        .in_ready     (sub_ready),
        .out_valid    (sub_mem_valid),
        .out_payload  (sub_mem_req),
        .credit_return(sub_credit_return),
        .credits      (sub_credits)
    );

endmodule

/* verification/tb_outrun_game.sv */
// Testbench for outrun_game with SDRAM slot models, reference functions and response checks
`timescale 1ns/10ps

module tb_outrun_game;

    localparam logic [21:0] KEY_BASE     = 22'h10_0000;
    localparam int          MAIN_CREDITS = 4;
    localparam int          SUB_CREDITS  = 2;
    localparam int          KEY_WORDS    = 64;
    localparam int          NUM_REQS     = 40 + KEY_WORDS;
    localparam int          CYCLE_LIMIT  = 40 * NUM_REQS;

    logic clk;
    logic reset;
    logic [21:0] prog_addr;
    logic [7:0] prog_data;
    logic prog_we;
    logic prom_we;
    logic header;
    logic [1:0] game_id;
    logic [7:0] st_addr;
    logic [7:0] st_dout;
    logic cpu_valid;
    outrun_bus_pkg::cpu_req_t cpu_req;
    logic cpu_ready;
    logic cpu_rsp_valid;
    outrun_bus_pkg::mem_rsp_t cpu_rsp;
    logic sub_valid;
    outrun_bus_pkg::sub_req_t sub_req;
    logic sub_ready;
    logic sub_rsp_valid;
    outrun_bus_pkg::mem_rsp_t sub_rsp;
    logic main_mem_valid;
    outrun_bus_pkg::mem_req_t main_mem_req;
    logic main_credit_return = 1'b0;
    logic main_rsp_valid = 1'b0;
    outrun_bus_pkg::mem_rsp_t main_rsp = '0;
    logic sub_mem_valid;
    outrun_bus_pkg::sub_req_t sub_mem_req;
    logic sub_credit_return = 1'b0;
    logic sub_mem_rsp_valid = 1'b0;
    outrun_bus_pkg::mem_rsp_t sub_mem_rsp = '0;

    // Expected traffic, memory model state and reference shadows
    outrun_bus_pkg::mem_req_t exp_main_req[$];
    outrun_bus_pkg::mem_rsp_t exp_main_rsp[$];
    outrun_bus_pkg::sub_req_t exp_sub_req[$];
    outrun_bus_pkg::mem_rsp_t exp_sub_rsp[$];
    outrun_bus_pkg::mem_req_t main_pend[$];
    outrun_bus_pkg::sub_req_t sub_pend[$];
    logic [15:0] xram_mem [logic [17:0]];
    logic [15:0] xram_ref [logic [17:0]];
    logic [31:0] rng_state = 32'h8c5a;
    logic [1:0] main_wait = 2'd0;
    logic [1:0] sub_wait = 2'd0;
    logic hold_main = 1'b0;
    logic cfg_en = 1'b0;
    logic cfg_type = 1'b0;
    logic [1:0] cfg_id = 2'd0;
    string current_test = "reset";
    int errors = 0;
    int test_errors_start = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;

    outrun_game #(
        .KEY_BASE    (KEY_BASE),
        .MAIN_CREDITS(MAIN_CREDITS),
        .SUB_CREDITS (SUB_CREDITS)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] key_byte(input logic [12:0] a);
        return a[7:0] ^ {a[12:8], 3'b101};
    endfunction

    function automatic logic [15:0] rom_word(input logic [17:0] a);
        return {a[7:0], a[15:8]} ^ {a[17:16], 14'h1c35};
    endfunction

    function automatic logic [15:0] xram_init(input logic [17:0] a);
        return a[15:0] ^ {a[17:16], 14'h2aaa};
    endfunction

    function automatic logic [15:0] sub_word(input outrun_bus_pkg::sub_req_t r);
        return r.rnw ? ({2'b00, r.addr} ^ 16'h6b29) : 16'h0000;
    endfunction

    // Region rule on byte address bits 19:18
    function automatic outrun_bus_pkg::mem_req_t ref_mem_req(input outrun_bus_pkg::cpu_req_t r);
        outrun_bus_pkg::mem_req_t m;
        m.dsn = r.dsn;
        m.din = r.din;
        if (r.addr[18] == 1'b0) begin
            m.bank = outrun_bus_pkg::BANK_ROM;
            m.addr = r.addr[17:0];
            m.we   = 1'b0;
        end else begin
            m.bank = outrun_bus_pkg::BANK_XRAM;
            m.addr = {3'b000, (r.addr[17:0] < 18'h2_0000), r.addr[13:0]};
            m.we   = ~r.rnw;
        end
        return m;
    endfunction

    function automatic logic [15:0] ref_decrypt(input logic [15:0] d, input logic [7:0] k,
                                                input logic en, input logic typ);
        if (!en) begin
            return d;
        end
        return typ ? (d ^ {k, ~k}) : (d ^ {k, k});
    endfunction

    function automatic logic [15:0] serve_main(input outrun_bus_pkg::mem_req_t r);
        if (r.bank == outrun_bus_pkg::BANK_ROM) begin
            return rom_word(r.addr);
        end
        if (r.we) begin
            xram_mem[r.addr] = r.din;
            return 16'h0000;
        end
        return xram_mem.exists(r.addr) ? xram_mem[r.addr] : xram_init(r.addr);
    endfunction

    task automatic check_rsp(input string name, input outrun_bus_pkg::mem_rsp_t exp,
                             input outrun_bus_pkg::mem_rsp_t act);
        if (exp !== act) begin
            $display("** Error: %s: response expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_mem_req(input string name, input outrun_bus_pkg::mem_req_t exp,
                                 input outrun_bus_pkg::mem_req_t act);
        if (exp !== act) begin
            $display("** Error: %s: main request expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_sub_req(input string name, input outrun_bus_pkg::sub_req_t exp,
                                 input outrun_bus_pkg::sub_req_t act);
        if (exp !== act) begin
            $display("** Error: %s: sub request expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("** Error: %s: status expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report(input string msg);
        $display("%s: %s", current_test, msg);
        errors++;
    endtask

    // Slot monitors compare what leaves the DUT and queue it for the memory models
    always @(negedge clk) begin
        if (!reset && main_mem_valid) begin
            if (exp_main_req.size() == 0) begin
                report("main slot request with none expected");
            end else begin
                check_mem_req(current_test, exp_main_req.pop_front(), main_mem_req);
            end
            main_pend.push_back(main_mem_req);
        end
        if (!reset && sub_mem_valid) begin
            if (exp_sub_req.size() == 0) begin
                report("sub slot request with none expected");
            end else begin
                check_sub_req(current_test, exp_sub_req.pop_front(), sub_mem_req);
            end
            sub_pend.push_back(sub_mem_req);
            if (sub_pend.size() > SUB_CREDITS) begin
                report("more sub requests outstanding than sub credits");
            end
        end
        if (!reset && cpu_rsp_valid) begin
            if (exp_main_rsp.size() == 0) begin
                report("main response with none expected");
            end else begin
                check_rsp(current_test, exp_main_rsp.pop_front(), cpu_rsp);
            end
        end
        if (!reset && sub_rsp_valid) begin
            if (exp_sub_rsp.size() == 0) begin
                report("sub response with none expected");
            end else begin
                check_rsp(current_test, exp_sub_rsp.pop_front(), sub_rsp);
            end
        end
    end

    // Memory models answer in order after a random delay, one credit per response
    always @(posedge clk) begin : main_server
        outrun_bus_pkg::mem_req_t r;
        #1;
        main_rsp_valid     = 1'b0;
        main_credit_return = 1'b0;
        if (main_wait != 2'd0) begin
            main_wait = main_wait - 2'd1;
        end else if (main_pend.size() > 0 && !hold_main) begin
            r                  = main_pend.pop_front();
            main_rsp.data      = serve_main(r);
            main_rsp_valid     = 1'b1;
            main_credit_return = 1'b1;
            rng_state          = xorshift(rng_state);
            main_wait          = rng_state[1:0];
        end
    end

    always @(posedge clk) begin : sub_server
        outrun_bus_pkg::sub_req_t r;
        #1;
        sub_mem_rsp_valid = 1'b0;
        sub_credit_return = 1'b0;
        if (sub_wait != 2'd0) begin
            sub_wait = sub_wait - 2'd1;
        end else if (sub_pend.size() > 0) begin
            r                 = sub_pend.pop_front();
            sub_mem_rsp.data  = sub_word(r);
            sub_mem_rsp_valid = 1'b1;
            sub_credit_return = 1'b1;
            rng_state         = xorshift(rng_state);
            sub_wait          = rng_state[3:2];
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Tasks start and end 1 ns after a rising edge
    task automatic hdr_write(input logic [3:0] off, input logic [7:0] data);
        header    = 1'b1;
        prog_we   = 1'b1;
        prog_addr = {18'd0, off};
        prog_data = data;
        @(posedge clk);
        #1;
        header  = 1'b0;
        prog_we = 1'b0;
        if (off == outrun_cfg_pkg::HDR_DEC_BYTE) begin
            cfg_type = data[0];
            cfg_en   = data[1];
        end
        if (off == outrun_cfg_pkg::HDR_ID_BYTE) begin
            cfg_id = data[1:0];
        end
    endtask

    task automatic load_keys();
        for (int i = 0; i < KEY_WORDS; i++) begin
            prom_we   = 1'b1;
            prog_addr = KEY_BASE | 22'(i);
            prog_data = key_byte(13'(i));
            @(posedge clk);
            #1;
        end
        prom_we = 1'b0;
    endtask

    task automatic read_status(input outrun_cfg_pkg::st_sel_e sel, output logic [7:0] v);
        st_addr = {6'd0, sel};
        @(posedge clk);
        @(negedge clk);
        v = st_dout;
        @(posedge clk);
        #1;
    endtask

    task automatic main_issue(input logic [18:0] addr, input logic rnw, input logic [15:0] din);
        outrun_bus_pkg::cpu_req_t r;
        outrun_bus_pkg::mem_req_t m;
        outrun_bus_pkg::mem_rsp_t e;
        logic acc;
        r.addr    = addr;
        r.dsn     = 2'b00;
        r.rnw     = rnw;
        r.din     = din;
        cpu_req   = r;
        cpu_valid = 1'b1;
        acc       = 1'b0;
        while (!acc) begin
            @(negedge clk);
            acc = cpu_ready;
            @(posedge clk);
            #1;
        end
        cpu_valid = 1'b0;
        m = ref_mem_req(r);
        exp_main_req.push_back(m);
        if (m.bank == outrun_bus_pkg::BANK_ROM) begin
            e.data = rom_word(m.addr);
            if (rnw) begin
                e.data = ref_decrypt(e.data, key_byte(addr[12:0]), cfg_en, cfg_type);
            end
        end else if (m.we) begin
            xram_ref[m.addr] = din;
            e.data = 16'h0000;
        end else begin
            e.data = xram_ref.exists(m.addr) ? xram_ref[m.addr] : xram_init(m.addr);
        end
        exp_main_rsp.push_back(e);
    endtask

    task automatic sub_issue(input logic [13:0] addr, input logic rnw, input logic [15:0] din);
        outrun_bus_pkg::sub_req_t r;
        outrun_bus_pkg::mem_rsp_t e;
        logic acc;
        r.addr    = addr;
        r.dsn     = 2'b00;
        r.rnw     = rnw;
        r.din     = din;
        sub_req   = r;
        sub_valid = 1'b1;
        acc       = 1'b0;
        while (!acc) begin
            @(negedge clk);
            acc = sub_ready;
            @(posedge clk);
            #1;
        end
        sub_valid = 1'b0;
        exp_sub_req.push_back(r);
        e.data = sub_word(r);
        exp_sub_rsp.push_back(e);
    endtask

    task automatic start_test(input string name);
        current_test      = name;
        test_errors_start = errors;
    endtask

    task automatic end_test();
        while (exp_main_req.size() + exp_main_rsp.size() + exp_sub_req.size()
               + exp_sub_rsp.size() != 0) begin
            @(posedge clk);
            #1;
        end
        tests_run++;
        if (errors == test_errors_start) begin
            $display("%-20s ok", current_test);
        end else begin
            tests_failed++;
            $display("%-20s failed with %0d errors", current_test, errors - test_errors_start);
        end
    endtask

    initial begin : stimulus
        logic [7:0] v;
        reset = 1'b1;
        prog_addr = '0;
        prog_data = '0;
        prog_we = 1'b0;
        prom_we = 1'b0;
        header = 1'b0;
        st_addr = '0;
        cpu_valid = 1'b0;
        cpu_req = '0;
        sub_valid = 1'b0;
        sub_req = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("header_cfg");
        hdr_write(outrun_cfg_pkg::HDR_DEC_BYTE, 8'h01);
        hdr_write(outrun_cfg_pkg::HDR_ID_BYTE, 8'h02);
        read_status(outrun_cfg_pkg::ST_CFG, v);
        check_byte(current_test, {4'b0000, cfg_id, cfg_type, cfg_en}, v);
        check_byte(current_test, {6'd0, cfg_id}, {6'd0, game_id});
        hdr_write(outrun_cfg_pkg::HDR_DEC_BYTE, 8'h00);
        end_test();

        start_test("plain_regions");
        main_issue(19'h0_0123, 1'b1, 16'h0000);
        main_issue(19'h2_3456, 1'b1, 16'h0000);
        main_issue(19'h0_0077, 1'b0, 16'hbeef);
        main_issue(19'h4_0042, 1'b1, 16'h0000);
        main_issue(19'h6_0100, 1'b1, 16'h0000);
        main_issue(19'h4_1234, 1'b0, 16'h1357);
        end_test();

        start_test("rom_decrypt");
        load_keys();
        hdr_write(outrun_cfg_pkg::HDR_DEC_BYTE, 8'h02);
        main_issue(19'h0_0005, 1'b1, 16'h0000);
        main_issue(19'h2_003a, 1'b1, 16'h0000);
        main_issue(19'h4_0010, 1'b1, 16'h0000);
        main_issue(19'h0_4011, 1'b1, 16'h0000);
        hdr_write(outrun_cfg_pkg::HDR_DEC_BYTE, 8'h03);
        main_issue(19'h0_0021, 1'b1, 16'h0000);
        main_issue(19'h3_e03f, 1'b1, 16'h0000);
        main_issue(19'h1_0002, 1'b1, 16'h0000);
        main_issue(19'h0_0030, 1'b1, 16'h0000);
        end_test();
        hdr_write(outrun_cfg_pkg::HDR_DEC_BYTE, 8'h00);

        start_test("xram_write_read");
        for (int i = 0; i < 2; i++) begin
            main_issue(19'h4_0200 + 19'(i), 1'b0, 16'ha000 + 16'(i));
            main_issue(19'h6_0300 + 19'(i), 1'b0, 16'hc000 + 16'(i));
        end
        for (int i = 0; i < 2; i++) begin
            main_issue(19'h4_0200 + 19'(i), 1'b1, 16'h0000);
            main_issue(19'h6_0300 + 19'(i), 1'b1, 16'h0000);
        end
        end_test();

        start_test("back_pressure");
        hold_main = 1'b1;
        for (int i = 0; i < MAIN_CREDITS; i++) begin
            main_issue(19'h6_0300 + 19'(i), 1'b1, 16'h0000);
        end
        @(negedge clk);
        if (cpu_ready) begin
            report("cpu_ready stayed high with all main credits in use");
        end
        @(posedge clk);
        #1;
        read_status(outrun_cfg_pkg::ST_MAIN_CRED, v);
        check_byte(current_test, 8'h00, v);
        hold_main = 1'b0;
        end_test();

        start_test("sub_slot");
        for (int i = 0; i < 6; i++) begin
            sub_issue(14'h0400 + 14'(i * 3), (i % 2) == 0, 16'h7100 + 16'(i));
        end
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
rtl/outrun_cfg_pkg.sv
rtl/outrun_bus_pkg.sv
rtl/game_cfg_regs.sv
rtl/key_prom.sv
rtl/main_mem_map.sv
rtl/credit_tx.sv
rtl/outrun_game.sv
verification/tb_outrun_game.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass message
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
    --top-module tb_outrun_game \
    -f files.f

./obj_dir/Vtb_outrun_game > sim.log 2>&1 || true
cat sim.log

grep -q "^TEST PASSED$" sim.log
